//--- src/sti_dac_pkg.sv
`default_nettype none

package sti_dac_pkg;

    typedef logic [15:0] word_t;       // host data word.
    typedef logic [31:0] frame_t;      // framed word before shifting.
    typedef logic [1:0]  len_code_t;   // 0:8, 1:16, 2:24, 3:32 bits.
    typedef logic [5:0]  bit_count_t;  // bits left, 0 to 32.
    typedef logic [7:0]  pixel_t;
    typedef logic [4:0]  bank_addr_t;
    typedef logic [3:0]  bank_sel_t;   // one-hot within a group.
    typedef logic [7:0]  pixel_idx_t;

    // image geometry
    localparam int PIXEL_COUNT     = 256;
    localparam int BANK_DEPTH      = 32;
    localparam int BANKS_PER_GROUP = 4;

endpackage

`default_nettype wire

//--- src/sti_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sti_ctrl
(
    input  wire  clk,
    input  wire  reset,
    input  wire  load,
    input  wire  done,
    output logic start,
    output logic busy
);

    typedef enum logic
    {
        idle,
        shift
    } state_t;

    state_t state;
    state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
            begin
                if (load)
                    state_next = shift;
            end
            shift:
            begin
                if (done)
                    state_next = idle;
            end
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= idle;
        else
            state <= state_next;
    end

    assign start = load && (state == idle);  // frame and count captured on this edge.
    assign busy  = (state == shift);

    // host must wait for so_valid to drop before the next load
    a_no_load_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !load);

endmodule

`default_nettype wire

//--- src/bit_counter.sv
`timescale 1ns/10ps
`default_nettype none

module bit_counter
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    start,
    input  sti_dac_pkg::len_code_t length,
    input  wire                    busy,
    output logic                   done
);

    sti_dac_pkg::bit_count_t count;  // bits left after the current one.

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= sti_dac_pkg::bit_count_t'({length, 3'b111});  // length minus one.
        else if (busy && count != '0)
            count <= count - 1'b1;
    end

    assign done = busy && (count == '0);

    // the FSM has to leave shift once the last bit is out
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        busy && count == '0 |=> !busy);

endmodule

`default_nettype wire

//--- src/sti_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module sti_shifter
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    start,
    input  sti_dac_pkg::word_t     data,
    input  sti_dac_pkg::len_code_t length,
    input  wire                    fill,
    input  wire                    msb,
    input  wire                    low,
    input  wire                    busy,
    output logic                   so_data,
    output logic                   so_valid
);

    sti_dac_pkg::frame_t framed;     // right aligned, length bits wide.
    sti_dac_pkg::frame_t msb_first;
    sti_dac_pkg::frame_t lsb_first;
    sti_dac_pkg::frame_t shift_q;
    logic [4:0]          unused_bits;

    always_comb
    begin
        case (length)
            2'd0:
                framed = sti_dac_pkg::frame_t'(low ? data[15:8] : data[7:0]);
            2'd1:
                framed = sti_dac_pkg::frame_t'(data);
            2'd2:
                framed = fill ? sti_dac_pkg::frame_t'({data, 8'h00})
                              : sti_dac_pkg::frame_t'(data);
            default:
                framed = fill ? {data, 16'h0000} : sti_dac_pkg::frame_t'(data);
        endcase
    end

    // both orders end up left aligned, so shifting is always toward bit 31
    assign unused_bits = {~length, 3'b000};
    assign msb_first   = framed << unused_bits;
    assign lsb_first   = {<<{framed}};  // bit 0 lands on bit 31.

    always_ff @(posedge clk)
    begin
        if (start)
            shift_q <= msb ? msb_first : lsb_first;
        else if (busy)
            shift_q <= shift_q << 1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            so_data  <= 1'b0;
            so_valid <= 1'b0;
        end
        else
        begin
            so_data  <= busy && shift_q[31];
            so_valid <= busy;
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_packer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_packer
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 so_data,
    input  wire                 so_valid,
    input  wire                 pad_en,
    input  wire                 finish,
    output logic                pix_valid,
    output sti_dac_pkg::pixel_t pix_data
);

    logic [2:0] bit_cnt;
    logic [6:0] partial;  // earlier bits of the byte, oldest on top.
    logic       pad_bit;
    logic       take;
    logic       bit_in;

    assign pad_bit = pad_en && !so_valid && !finish;  // zero fill to end of image.
    assign take    = so_valid || pad_bit;
    assign bit_in  = so_valid && so_data;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bit_cnt   <= '0;
            pix_valid <= 1'b0;
        end
        else
        begin
            pix_valid <= take && (bit_cnt == 3'd7);
            if (take)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            partial <= {partial[5:0], bit_in};
        if (take && bit_cnt == 3'd7)
            pix_data <= {partial, bit_in};
    end

    // pi_end may only come after the last word has left the shifter
    a_single_source: assert property (@(posedge clk) disable iff (reset)
        so_valid |-> !pad_en);

endmodule

`default_nettype wire

//--- src/bank_writer.sv
`timescale 1ns/10ps
`default_nettype none

module bank_writer
#(
    parameter int IMG_WIDTH = 16
)
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     pix_valid,
    input  sti_dac_pkg::pixel_t     pix_data,
    output sti_dac_pkg::pixel_t     oem_dataout,
    output sti_dac_pkg::bank_addr_t oem_addr,
    output sti_dac_pkg::bank_sel_t  odd_wr,
    output sti_dac_pkg::bank_sel_t  even_wr,
    output logic                    oem_finish
);

    localparam int GROUP_BITS =
        $clog2(sti_dac_pkg::BANK_DEPTH * sti_dac_pkg::BANKS_PER_GROUP);

    sti_dac_pkg::pixel_idx_t idx;
    sti_dac_pkg::pixel_idx_t row;
    sti_dac_pkg::pixel_idx_t col;
    logic [GROUP_BITS-1:0]   odd_cnt;
    logic [GROUP_BITS-1:0]   even_cnt;
    logic [GROUP_BITS-1:0]   cur_cnt;
    sti_dac_pkg::bank_sel_t  bank_sel;
    logic                    to_odd;
    logic                    write;
    logic                    last_wr;

    assign row    = sti_dac_pkg::pixel_idx_t'(idx / IMG_WIDTH);
    assign col    = sti_dac_pkg::pixel_idx_t'(idx % IMG_WIDTH);
    assign to_odd = !(row[0] ^ col[0]);  // row plus column even.
    assign write  = pix_valid && !oem_finish;

    assign cur_cnt  = to_odd ? odd_cnt : even_cnt;
    assign bank_sel = sti_dac_pkg::bank_sel_t'(1) << (cur_cnt / sti_dac_pkg::BANK_DEPTH);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idx        <= '0;
            odd_cnt    <= '0;
            even_cnt   <= '0;
            odd_wr     <= '0;
            even_wr    <= '0;
            last_wr    <= 1'b0;
            oem_finish <= 1'b0;
        end
        else
        begin
            odd_wr     <= (write && to_odd) ? bank_sel : '0;
            even_wr    <= (write && !to_odd) ? bank_sel : '0;
            last_wr    <= write && (idx == sti_dac_pkg::pixel_idx_t'(sti_dac_pkg::PIXEL_COUNT - 1));
            oem_finish <= oem_finish || last_wr;  // held until reset.
            if (write)
            begin
                idx <= idx + 1'b1;
                if (to_odd)
                    odd_cnt <= odd_cnt + 1'b1;
                else
                    even_cnt <= even_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (write)
        begin
            oem_dataout <= pix_data;
            oem_addr    <= sti_dac_pkg::bank_addr_t'(cur_cnt % sti_dac_pkg::BANK_DEPTH);
        end
    end

    // each pixel gives exactly one strobe cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        (odd_wr != '0 || even_wr != '0) |=> (odd_wr == '0 && even_wr == '0));

endmodule

`default_nettype wire

//--- src/sti_dac.sv
`timescale 1ns/10ps
`default_nettype none

module sti_dac
#(
    parameter int IMG_WIDTH = 16
)
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     load,
    input  sti_dac_pkg::word_t      pi_data,
    input  sti_dac_pkg::len_code_t  pi_length,
    input  wire                     pi_fill,
    input  wire                     pi_msb,
    input  wire                     pi_low,
    input  wire                     pi_end,
    output logic                    so_data,
    output logic                    so_valid,
    output sti_dac_pkg::pixel_t     oem_dataout,
    output sti_dac_pkg::bank_addr_t oem_addr,
    output sti_dac_pkg::bank_sel_t  odd_wr,
    output sti_dac_pkg::bank_sel_t  even_wr,
    output logic                    oem_finish
);

    logic                start;
    logic                busy;
    logic                done;
    logic                pix_valid;
    sti_dac_pkg::pixel_t pix_data;

    sti_ctrl u_ctrl (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .done  (done),
        .start (start),
        .busy  (busy)
    );

    bit_counter u_bit_counter (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .length (pi_length),
        .busy   (busy),
        .done   (done)
    );

    sti_shifter u_shifter (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .data     (pi_data),
        .length   (pi_length),
        .fill     (pi_fill),
        .msb      (pi_msb),
        .low      (pi_low),
        .busy     (busy),
        .so_data  (so_data),
        .so_valid (so_valid)
    );

    pixel_packer u_packer (
        .clk       (clk),
        .reset     (reset),
        .so_data   (so_data),
        .so_valid  (so_valid),
        .pad_en    (pi_end),
        .finish    (oem_finish),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

    bank_writer #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_bank_writer (
        .clk         (clk),
        .reset       (reset),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .oem_dataout (oem_dataout),
        .oem_addr    (oem_addr),
        .odd_wr      (odd_wr),
        .even_wr     (even_wr),
        .oem_finish  (oem_finish)
    );

endmodule

`default_nettype wire

//--- test/sti_dac_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sti_dac_tb;

    localparam int IMG_WIDTH   = 16;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 5;  // len, fill, msb, low, data.
    localparam int PIXELS      = sti_dac_pkg::PIXEL_COUNT;
    localparam int IMAGE_BITS  = PIXELS * 8;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    load;
    sti_dac_pkg::word_t      pi_data;
    sti_dac_pkg::len_code_t  pi_length;
    logic                    pi_fill;
    logic                    pi_msb;
    logic                    pi_low;
    logic                    pi_end;
    logic                    so_data;
    logic                    so_valid;
    sti_dac_pkg::pixel_t     oem_dataout;
    sti_dac_pkg::bank_addr_t oem_addr;
    sti_dac_pkg::bank_sel_t  odd_wr;
    sti_dac_pkg::bank_sel_t  even_wr;
    logic                    oem_finish;

    logic [15:0]            raw_words [0:FIELDS*MAX_VECTORS-1];
    sti_dac_pkg::len_code_t v_len     [0:MAX_VECTORS-1];
    logic                   v_fill    [0:MAX_VECTORS-1];
    logic                   v_msb     [0:MAX_VECTORS-1];
    logic                   v_low     [0:MAX_VECTORS-1];
    sti_dac_pkg::word_t     v_data    [0:MAX_VECTORS-1];
    int                     v_start   [0:MAX_VECTORS-1];  // first stream bit of the word.
    logic                   exp_bits  [0:IMAGE_BITS-1];   // whole image, zero padded.
    int                     num_vectors;
    int                     watch_cycles = 0;
    int                     wr_count = 0;
    int                     odd_count = 0;
    int                     even_count = 0;
    int                     odd_strobes = 0;   // as seen on odd_wr.
    int                     even_strobes = 0;  // as seen on even_wr.

    sti_dac #(
        .IMG_WIDTH (IMG_WIDTH)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .pi_data     (pi_data),
        .pi_length   (pi_length),
        .pi_fill     (pi_fill),
        .pi_msb      (pi_msb),
        .pi_low      (pi_low),
        .pi_end      (pi_end),
        .so_data     (so_data),
        .so_valid    (so_valid),
        .oem_dataout (oem_dataout),
        .oem_addr    (oem_addr),
        .odd_wr      (odd_wr),
        .even_wr     (even_wr),
        .oem_finish  (oem_finish)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s (time %0t)", what, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic int word_bits(input sti_dac_pkg::len_code_t len);
        return 8 * (int'(len) + 1);
    endfunction

    // right aligned frame, word_bits wide
    function automatic logic [31:0] frame_value(input int i);
        case (v_len[i])
            2'd0:    return v_low[i] ? {24'h0, v_data[i][15:8]} : {24'h0, v_data[i][7:0]};
            2'd1:    return {16'h0, v_data[i]};
            2'd2:    return v_fill[i] ? {8'h0, v_data[i], 8'h00} : {16'h0, v_data[i]};
            default: return v_fill[i] ? {v_data[i], 16'h0} : {16'h0, v_data[i]};
        endcase
    endfunction

    function automatic logic stream_bit(input int i, input int j);
        logic [31:0] frame;
        int          len;
        frame = frame_value(i);
        len   = word_bits(v_len[i]);
        return v_msb[i] ? frame[len - 1 - j] : frame[j];
    endfunction

    function automatic logic [7:0] model_pixel(input int k);
        logic [7:0] p;
        int         b;
        p = '0;
        for (b = 0; b < 8; b++)
            p = {p[6:0], exp_bits[8 * k + b]};  // first bit ends on bit 7.
        return p;
    endfunction

    task automatic read_vectors();
        int a;
        int i;
        int j;
        int base;
        for (a = 0; a < FIELDS * MAX_VECTORS; a++)
            raw_words[a] = 16'hffff;  // end marker.
        for (a = 0; a < IMAGE_BITS; a++)
            exp_bits[a] = 1'b0;
        $readmemh("test/sti_dac_vectors.txt", raw_words);
        num_vectors = 0;
        base        = 0;
        while (num_vectors < MAX_VECTORS && raw_words[FIELDS * num_vectors] != 16'hffff)
        begin
            i          = num_vectors;
            v_len[i]   = raw_words[FIELDS * i][1:0];
            v_fill[i]  = raw_words[FIELDS * i + 1][0];
            v_msb[i]   = raw_words[FIELDS * i + 2][0];
            v_low[i]   = raw_words[FIELDS * i + 3][0];
            v_data[i]  = raw_words[FIELDS * i + 4];
            v_start[i] = base;
            base       = base + word_bits(v_len[i]);
            num_vectors++;
        end
        if (num_vectors == 0)
            report_failure("No vectors could be read from test/sti_dac_vectors.txt");
        if (base > IMAGE_BITS)
            report_failure("The vectors hold more bits than one image");
        for (i = 0; i < num_vectors; i++)
            for (j = 0; j < word_bits(v_len[i]); j++)
                exp_bits[v_start[i] + j] = stream_bit(i, j);
        watch_cycles = base + IMAGE_BITS + 200;
    endtask

    task automatic send_word(input int i);
        int len;
        int j;
        len = word_bits(v_len[i]);
        @(posedge clk);
        #(DRIVE_DELAY);
        check_value("so_valid", 32'(so_valid), 32'd0);
        load      = 1'b1;
        pi_data   = v_data[i];
        pi_length = v_len[i];
        pi_fill   = v_fill[i];
        pi_msb    = v_msb[i];
        pi_low    = v_low[i];
        @(posedge clk);  // load sampled here.
        #(DRIVE_DELAY);
        load      = 1'b0;
        pi_data   = ~v_data[i];  // only the load cycle counts.
        pi_length = ~v_len[i];
        pi_fill   = ~v_fill[i];
        pi_msb    = ~v_msb[i];
        pi_low    = ~v_low[i];
        check_value("so_valid", 32'(so_valid), 32'd0);
        for (j = 0; j < len; j++)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_value("so_valid", 32'(so_valid), 32'd1);
            check_value("so_data", 32'(so_data), 32'(exp_bits[v_start[i] + j]));
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        check_value("so_valid", 32'(so_valid), 32'd0);
    endtask

    task automatic check_write();
        int          row;
        int          col;
        int          n;
        logic        to_odd;
        logic [31:0] sel;
        if (wr_count >= PIXELS)
            report_failure("A write strobe came after the last pixel");
        row    = wr_count / IMG_WIDTH;
        col    = wr_count % IMG_WIDTH;
        to_odd = ((row + col) % 2) == 0;  // pixel 0 goes to the odd group.
        n      = to_odd ? odd_count : even_count;
        sel    = 32'(1) << (n / sti_dac_pkg::BANK_DEPTH);
        check_value("odd_wr", 32'(odd_wr), to_odd ? sel : 32'd0);
        check_value("even_wr", 32'(even_wr), to_odd ? 32'd0 : sel);
        check_value("oem_addr", 32'(oem_addr), n % sti_dac_pkg::BANK_DEPTH);
        check_value("oem_dataout", 32'(oem_dataout), 32'(model_pixel(wr_count)));
        if (to_odd)
            odd_count++;
        else
            even_count++;
        wr_count++;
    endtask

    // writes and finish are sampled mid cycle.
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_value("oem_finish", 32'(oem_finish), 32'(wr_count == PIXELS));
            if (odd_wr != '0)
                odd_strobes++;
            if (even_wr != '0)
                even_strobes++;
            if (odd_wr != '0 || even_wr != '0)
                check_write();
        end
    end

    initial
    begin
        wait (watch_cycles != 0);
        #(watch_cycles * CLK_PERIOD);
        $display("Timeout: the image was not finished within %0d cycles", watch_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial
    begin
        int i;
        reset     = 1'b1;
        load      = 1'b0;
        pi_data   = '0;
        pi_length = '0;
        pi_fill   = 1'b0;
        pi_msb    = 1'b0;
        pi_low    = 1'b0;
        pi_end    = 1'b0;
        read_vectors();
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        check_value("so_valid", 32'(so_valid), 32'd0);
        check_value("so_data", 32'(so_data), 32'd0);
        check_value("odd_wr", 32'(odd_wr), 32'd0);
        check_value("even_wr", 32'(even_wr), 32'd0);
        check_value("oem_finish", 32'(oem_finish), 32'd0);
        for (i = 0; i < num_vectors; i++)
            send_word(i);
        pi_end = 1'b1;  // rest of the image is zero fill.
        while (!oem_finish)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        repeat (8)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_value("oem_finish", 32'(oem_finish), 32'd1);
        end
        check_value("write count", wr_count, PIXELS);
        check_value("odd group writes", odd_strobes, PIXELS / 2);
        check_value("even group writes", even_strobes, PIXELS / 2);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sti_dac_vectors.txt
// len fill msb low data, all hex, one word per line
// len 0, 1, 2, 3 is 8, 16, 24, 32 bits
0 0 1 0 a5c3
0 0 1 1 a5c3
0 0 0 0 1e2d
0 0 0 1 1e2d
1 0 1 0 8001
1 0 0 0 8001
1 0 1 0 f00f
2 1 1 0 c3a5
2 0 1 0 c3a5
2 1 0 0 5a3c
2 0 0 0 5a3c
2 0 1 0 1234
2 1 1 0 5678
2 0 1 0 9abc
3 1 1 0 dead
3 0 1 0 beef
3 1 0 0 0f1e
3 0 0 0 7c81
0 1 1 1 ff00
1 1 0 1 6b29

//--- vlog.f
src/sti_dac_pkg.sv
src/sti_ctrl.sv
src/bit_counter.sv
src/sti_shifter.sv
src/pixel_packer.sv
src/bank_writer.sv
src/sti_dac.sv
test/sti_dac_tb.sv

//--- Makefile
# Verilator build for the sti_dac testbench.
VERILATOR ?= verilator
TOP       ?= sti_dac_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# the run's exit status is the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
